// ==== include/bus_consts.svh ====
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Address and data widths
`define BUS_ADDR_W   32
`define BUS_DATA_W   64
`define CORE_DATA_W  32

// Byte strobes, one per byte
`define BUS_STRB_W   8
`define CORE_STRB_W  4

// A bus word holds two core words
`define BUS_LANES    2

// Accepted requests still waiting for their response
`define BUS_MAX_OUTSTANDING 2

// Source index of each arbiter port
`define BUS_PORT_DATA  1'b0
`define BUS_PORT_FETCH 1'b1

`endif

// ==== hw/bus_pkg.sv ====
package bus_pkg;

    // ----------------------------------------
    // Transfer size
    // ----------------------------------------
    // Encodes log2 of the byte count
    typedef enum logic [2:0] {
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3
    } bus_size_e;

    // ----------------------------------------
    // Fetch bridge states
    // ----------------------------------------
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ISSUE,
        FETCH_WAIT
    } fetch_state_e;

    // ----------------------------------------
    // Arbiter source port
    // ----------------------------------------
    // 0 is the data port, 1 the fetch port
    typedef logic port_idx_t;

endpackage

// ==== hw/inst_fetch_bridge.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module inst_fetch_bridge
    import bus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Core fetch port
    input  logic                    inst_req_i,
    input  logic [`BUS_ADDR_W-1:0]  inst_addr_i,
    output logic                    inst_ack_o,
    output logic [`CORE_DATA_W-1:0] inst_rdata_o,
    // Request channel
    output logic                    q_valid_o,
    input  logic                    q_ready_i,
    output logic [`BUS_ADDR_W-1:0]  q_addr_o,
    output bus_size_e               q_size_o,
    // Response channel
    input  logic                    p_valid_i,
    output logic                    p_ready_o,
    input  logic [`BUS_DATA_W-1:0]  p_rdata_i
);

    // Offset bits of a bus word and the bit that selects the upper lane
    localparam int unsigned OFFS_W   = $clog2(`BUS_STRB_W);
    localparam int unsigned LANE_BIT = $clog2(`BUS_STRB_W / `BUS_LANES);

    fetch_state_e           state_q;
    fetch_state_e           state_d;
    logic [`BUS_ADDR_W-1:0] addr_q;
    logic                   upper_q;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (inst_req_i) begin
                    state_d = FETCH_ISSUE;
                end
            end
            // Hold the read until the arbiter takes it
            FETCH_ISSUE: begin
                if (q_ready_i) begin
                    state_d = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (p_valid_i) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    // Capture the 8-byte aligned address and which half was asked for
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH_IDLE && inst_req_i) begin
            addr_q  <= {inst_addr_i[`BUS_ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            upper_q <= inst_addr_i[LANE_BIT];
        end
    end

    // ----------------------------------------
    // Bus side and core response
    // ----------------------------------------
    assign q_valid_o = (state_q == FETCH_ISSUE);
    assign q_addr_o  = addr_q;
    assign q_size_o  = SIZE_DWORD;
    assign p_ready_o = 1'b1;

    assign inst_ack_o   = p_valid_i & p_ready_o;
    assign inst_rdata_o = upper_q ? p_rdata_i[`BUS_DATA_W-1 -: `CORE_DATA_W]
                                  : p_rdata_i[`CORE_DATA_W-1:0];

endmodule

// ==== hw/data_access_bridge.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module data_access_bridge
    import bus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Core load/store port
    input  logic                    data_req_i,
    input  logic                    data_we_i,
    input  logic [`BUS_ADDR_W-1:0]  data_addr_i,
    input  logic [`CORE_DATA_W-1:0] data_wdata_i,
    input  logic [`CORE_STRB_W-1:0] data_strb_i,
    output logic                    data_ack_o,
    output logic [`CORE_DATA_W-1:0] data_rdata_o,
    output logic                    data_error_o,
    // Request channel
    output logic                    q_valid_o,
    input  logic                    q_ready_i,
    output logic [`BUS_ADDR_W-1:0]  q_addr_o,
    output logic                    q_write_o,
    output logic [`BUS_DATA_W-1:0]  q_wdata_o,
    output logic [`BUS_STRB_W-1:0]  q_strb_o,
    output bus_size_e               q_size_o,
    // Response channel
    input  logic                    p_valid_i,
    output logic                    p_ready_o,
    input  logic [`BUS_DATA_W-1:0]  p_rdata_i,
    input  logic                    p_error_i
);

    localparam int unsigned OFFS_W   = $clog2(`CORE_STRB_W);
    localparam int unsigned LANE_BIT = $clog2(`BUS_STRB_W / `BUS_LANES);

    logic pending_q;
    logic q_fire;
    logic p_fire;
    logic upper;

    assign q_fire = q_valid_o & q_ready_i;
    assign p_fire = p_valid_i & p_ready_o;
    assign upper  = data_addr_i[LANE_BIT];

    // ----------------------------------------
    // Outstanding request
    // ----------------------------------------
    // Set on acceptance, cleared when the response is taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (p_fire) begin
            pending_q <= 1'b0;
        end else if (q_fire) begin
            pending_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // Request with lane placement
    // ----------------------------------------
    assign q_valid_o = data_req_i & ~pending_q;
    assign q_addr_o  = {data_addr_i[`BUS_ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign q_write_o = data_we_i;
    assign q_size_o  = SIZE_WORD;
    assign q_wdata_o = upper ? {data_wdata_i, {`CORE_DATA_W{1'b0}}}
                             : {{`CORE_DATA_W{1'b0}}, data_wdata_i};
    assign q_strb_o  = upper ? {data_strb_i, {`CORE_STRB_W{1'b0}}}
                             : {{`CORE_STRB_W{1'b0}}, data_strb_i};

    // ----------------------------------------
    // Response
    // ----------------------------------------
    // Core holds its address until ack, so it still picks the lane here
    assign p_ready_o    = data_req_i;
    assign data_ack_o   = p_fire;
    assign data_rdata_o = upper ? p_rdata_i[`BUS_DATA_W-1 -: `CORE_DATA_W]
                                : p_rdata_i[`CORE_DATA_W-1:0];
    assign data_error_o = p_error_i;

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_arbiter
    import bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Fetch side
    input  logic                   f_q_valid_i,
    output logic                   f_q_ready_o,
    input  logic [`BUS_ADDR_W-1:0] f_q_addr_i,
    input  logic                   f_q_write_i,
    input  logic [`BUS_DATA_W-1:0] f_q_wdata_i,
    input  logic [`BUS_STRB_W-1:0] f_q_strb_i,
    input  bus_size_e              f_q_size_i,
    output logic                   f_p_valid_o,
    input  logic                   f_p_ready_i,
    output logic [`BUS_DATA_W-1:0] f_p_rdata_o,
    output logic                   f_p_error_o,
    // Data side
    input  logic                   d_q_valid_i,
    output logic                   d_q_ready_o,
    input  logic [`BUS_ADDR_W-1:0] d_q_addr_i,
    input  logic                   d_q_write_i,
    input  logic [`BUS_DATA_W-1:0] d_q_wdata_i,
    input  logic [`BUS_STRB_W-1:0] d_q_strb_i,
    input  bus_size_e              d_q_size_i,
    output logic                   d_p_valid_o,
    input  logic                   d_p_ready_i,
    output logic [`BUS_DATA_W-1:0] d_p_rdata_o,
    output logic                   d_p_error_o,
    // Shared bus
    output logic                   bus_q_valid_o,
    input  logic                   bus_q_ready_i,
    output logic [`BUS_ADDR_W-1:0] bus_q_addr_o,
    output logic                   bus_q_write_o,
    output logic [`BUS_DATA_W-1:0] bus_q_wdata_o,
    output logic [`BUS_STRB_W-1:0] bus_q_strb_o,
    output bus_size_e              bus_q_size_o,
    input  logic                   bus_p_valid_i,
    output logic                   bus_p_ready_o,
    input  logic [`BUS_DATA_W-1:0] bus_p_rdata_i,
    input  logic                   bus_p_error_i
);

    localparam int unsigned DEPTH = `BUS_MAX_OUTSTANDING;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    port_idx_t        grant_idx;
    port_idx_t        last_q;
    port_idx_t        lock_idx_q;
    logic             lock_q;
    logic             sel_fetch;
    logic             q_fire;
    logic             p_fire;
    port_idx_t        fifo_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             fifo_full;
    logic             fifo_empty;
    logic             head_fetch;
    logic             head_data;

    // ----------------------------------------
    // Round-robin grant
    // ----------------------------------------
    // A grant shown but not taken stays locked
    always_comb begin
        if (lock_q) begin
            grant_idx = lock_idx_q;
        end else if (f_q_valid_i && d_q_valid_i) begin
            grant_idx = ~last_q;
        end else if (f_q_valid_i) begin
            grant_idx = `BUS_PORT_FETCH;
        end else begin
            grant_idx = `BUS_PORT_DATA;
        end
    end

    assign sel_fetch = (grant_idx == `BUS_PORT_FETCH);

    assign bus_q_valid_o = (sel_fetch ? f_q_valid_i : d_q_valid_i) & ~fifo_full;
    assign bus_q_addr_o  = sel_fetch ? f_q_addr_i  : d_q_addr_i;
    assign bus_q_write_o = sel_fetch ? f_q_write_i : d_q_write_i;
    assign bus_q_wdata_o = sel_fetch ? f_q_wdata_i : d_q_wdata_i;
    assign bus_q_strb_o  = sel_fetch ? f_q_strb_i  : d_q_strb_i;
    assign bus_q_size_o  = sel_fetch ? f_q_size_i  : d_q_size_i;

    assign f_q_ready_o = bus_q_ready_i & ~fifo_full & sel_fetch;
    assign d_q_ready_o = bus_q_ready_i & ~fifo_full & ~sel_fetch;
    assign q_fire      = bus_q_valid_o & bus_q_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lock_q     <= 1'b0;
            lock_idx_q <= `BUS_PORT_DATA;
            last_q     <= `BUS_PORT_FETCH;
        end else begin
            lock_q     <= bus_q_valid_o & ~bus_q_ready_i;
            lock_idx_q <= grant_idx;
            if (q_fire) begin
                last_q <= grant_idx;
            end
        end
    end

    // ----------------------------------------
    // Source index FIFO
    // ----------------------------------------
    assign fifo_full  = (count_q == CNT_W'(DEPTH));
    assign fifo_empty = (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (q_fire) begin
            fifo_q[wr_ptr_q] <= grant_idx;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (q_fire) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (p_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (q_fire && !p_fire) begin
                count_q <= count_q + 1'b1;
            end else if (p_fire && !q_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Response routing
    // ----------------------------------------
    // Memory answers in order, so the FIFO head owns the response
    assign head_fetch = ~fifo_empty & (fifo_q[rd_ptr_q] == `BUS_PORT_FETCH);
    assign head_data  = ~fifo_empty & (fifo_q[rd_ptr_q] == `BUS_PORT_DATA);

    assign f_p_valid_o   = bus_p_valid_i & head_fetch;
    assign d_p_valid_o   = bus_p_valid_i & head_data;
    assign bus_p_ready_o = (head_fetch & f_p_ready_i) | (head_data & d_p_ready_i);
    assign p_fire        = bus_p_valid_i & bus_p_ready_o;

    assign f_p_rdata_o = bus_p_rdata_i;
    assign d_p_rdata_o = bus_p_rdata_i;
    assign f_p_error_o = bus_p_error_i;
    assign d_p_error_o = bus_p_error_i;

endmodule

// ==== hw/core_bus_top.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module core_bus_top
    import bus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Core fetch port
    input  logic                    inst_req_i,
    input  logic [`BUS_ADDR_W-1:0]  inst_addr_i,
    output logic                    inst_ack_o,
    output logic [`CORE_DATA_W-1:0] inst_rdata_o,
    // Core load/store port
    input  logic                    data_req_i,
    input  logic                    data_we_i,
    input  logic [`BUS_ADDR_W-1:0]  data_addr_i,
    input  logic [`CORE_DATA_W-1:0] data_wdata_i,
    input  logic [`CORE_STRB_W-1:0] data_strb_i,
    output logic                    data_ack_o,
    output logic [`CORE_DATA_W-1:0] data_rdata_o,
    output logic                    data_error_o,
    // External memory bus
    output logic                    bus_q_valid_o,
    input  logic                    bus_q_ready_i,
    output logic [`BUS_ADDR_W-1:0]  bus_q_addr_o,
    output logic                    bus_q_write_o,
    output logic [`BUS_DATA_W-1:0]  bus_q_wdata_o,
    output logic [`BUS_STRB_W-1:0]  bus_q_strb_o,
    output bus_size_e               bus_q_size_o,
    input  logic                    bus_p_valid_i,
    output logic                    bus_p_ready_o,
    input  logic [`BUS_DATA_W-1:0]  bus_p_rdata_i,
    input  logic                    bus_p_error_i
);

    // ----------------------------------------
    // Bridge to arbiter wires
    // ----------------------------------------
    logic                   f_q_valid;
    logic                   f_q_ready;
    logic [`BUS_ADDR_W-1:0] f_q_addr;
    bus_size_e              f_q_size;
    logic                   f_p_valid;
    logic                   f_p_ready;
    logic [`BUS_DATA_W-1:0] f_p_rdata;

    logic                   d_q_valid;
    logic                   d_q_ready;
    logic [`BUS_ADDR_W-1:0] d_q_addr;
    logic                   d_q_write;
    logic [`BUS_DATA_W-1:0] d_q_wdata;
    logic [`BUS_STRB_W-1:0] d_q_strb;
    bus_size_e              d_q_size;
    logic                   d_p_valid;
    logic                   d_p_ready;
    logic [`BUS_DATA_W-1:0] d_p_rdata;
    logic                   d_p_error;

    // Core port and clock names match, the rest is wired by name
    inst_fetch_bridge i_inst_bridge (
        .q_valid_o (f_q_valid),
        .q_ready_i (f_q_ready),
        .q_addr_o  (f_q_addr),
        .q_size_o  (f_q_size),
        .p_valid_i (f_p_valid),
        .p_ready_o (f_p_ready),
        .p_rdata_i (f_p_rdata),
        .*
    );

    data_access_bridge i_data_bridge (
        .q_valid_o (d_q_valid),
        .q_ready_i (d_q_ready),
        .q_addr_o  (d_q_addr),
        .q_write_o (d_q_write),
        .q_wdata_o (d_q_wdata),
        .q_strb_o  (d_q_strb),
        .q_size_o  (d_q_size),
        .p_valid_i (d_p_valid),
        .p_ready_o (d_p_ready),
        .p_rdata_i (d_p_rdata),
        .p_error_i (d_p_error),
        .*
    );

    // Fetch side only reads, full strobes
    bus_arbiter i_arbiter (
        .f_q_valid_i (f_q_valid),
        .f_q_ready_o (f_q_ready),
        .f_q_addr_i  (f_q_addr),
        .f_q_write_i (1'b0),
        .f_q_wdata_i ({`BUS_DATA_W{1'b0}}),
        .f_q_strb_i  ({`BUS_STRB_W{1'b1}}),
        .f_q_size_i  (f_q_size),
        .f_p_valid_o (f_p_valid),
        .f_p_ready_i (f_p_ready),
        .f_p_rdata_o (f_p_rdata),
        .f_p_error_o (),
        .d_q_valid_i (d_q_valid),
        .d_q_ready_o (d_q_ready),
        .d_q_addr_i  (d_q_addr),
        .d_q_write_i (d_q_write),
        .d_q_wdata_i (d_q_wdata),
        .d_q_strb_i  (d_q_strb),
        .d_q_size_i  (d_q_size),
        .d_p_valid_o (d_p_valid),
        .d_p_ready_i (d_p_ready),
        .d_p_rdata_o (d_p_rdata),
        .d_p_error_o (d_p_error),
        .*
    );

endmodule

// ==== tests/core_bus_chk.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module core_bus_chk
    import bus_pkg::*;
(
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    bus_q_valid_i,
    input logic                    bus_q_ready_i,
    input logic [`BUS_ADDR_W-1:0]  bus_q_addr_i,
    input logic                    bus_q_write_i,
    input logic [`BUS_DATA_W-1:0]  bus_q_wdata_i,
    input logic [`BUS_STRB_W-1:0]  bus_q_strb_i,
    input bus_size_e               bus_q_size_i,
    input logic                    bus_p_valid_i,
    input logic                    bus_p_ready_i,
    input logic                    inst_ack_i,
    input logic                    data_ack_i,
    input fetch_state_e            fetch_state_i
);

    // Number of failed assertions, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // Requests accepted on the bus and not yet answered
    logic [2:0] outstanding_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
        end else begin
            outstanding_q <= outstanding_q
                           + 3'(bus_q_valid_i && bus_q_ready_i)
                           - 3'(bus_p_valid_i && bus_p_ready_i);
        end
    end

    // ----------------------------------------
    // Request channel
    // ----------------------------------------
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_q_valid_i && !bus_q_ready_i |=>
            bus_q_valid_i && $stable(bus_q_addr_i) && $stable(bus_q_write_i) &&
            $stable(bus_q_wdata_i) && $stable(bus_q_strb_i) && $stable(bus_q_size_i))
        else begin
            fail_cnt++;
            $error("Bus request dropped or changed while stalled");
        end

    // ----------------------------------------
    // Responses and acks
    // ----------------------------------------
    ack_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(inst_ack_i && data_ack_i))
        else begin
            fail_cnt++;
            $error("Fetch and data ack high in the same cycle");
        end

    rsp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_p_valid_i && bus_p_ready_i |-> outstanding_q != '0)
        else begin
            fail_cnt++;
            $error("Bus response taken with no request outstanding");
        end

    // One fetch in flight at a time
    fetch_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_state_i == FETCH_WAIT |-> !(bus_q_valid_i && bus_q_size_i == SIZE_DWORD))
        else begin
            fail_cnt++;
            $error("Fetch bridge requests while waiting for its response");
        end

endmodule

bind core_bus_top core_bus_chk i_chk (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus_q_valid_i   (bus_q_valid_o),
    .bus_q_ready_i   (bus_q_ready_i),
    .bus_q_addr_i    (bus_q_addr_o),
    .bus_q_write_i   (bus_q_write_o),
    .bus_q_wdata_i   (bus_q_wdata_o),
    .bus_q_strb_i    (bus_q_strb_o),
    .bus_q_size_i    (bus_q_size_o),
    .bus_p_valid_i   (bus_p_valid_i),
    .bus_p_ready_i   (bus_p_ready_o),
    .inst_ack_i      (inst_ack_o),
    .data_ack_i      (data_ack_o),
    .fetch_state_i   (i_inst_bridge.state_q)
);

// ==== tests/core_bus_tb.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module core_bus_tb
    import bus_pkg::*;
();

    localparam int          TIMEOUT   = 200;
    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] ERR_BASE  = 32'h0000_f000;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    inst_req_i;
    logic [`BUS_ADDR_W-1:0]  inst_addr_i;
    logic                    inst_ack_o;
    logic [`CORE_DATA_W-1:0] inst_rdata_o;
    logic                    data_req_i;
    logic                    data_we_i;
    logic [`BUS_ADDR_W-1:0]  data_addr_i;
    logic [`CORE_DATA_W-1:0] data_wdata_i;
    logic [`CORE_STRB_W-1:0] data_strb_i;
    logic                    data_ack_o;
    logic [`CORE_DATA_W-1:0] data_rdata_o;
    logic                    data_error_o;
    logic                    bus_q_valid_o;
    logic                    bus_q_ready_i;
    logic [`BUS_ADDR_W-1:0]  bus_q_addr_o;
    logic                    bus_q_write_o;
    logic [`BUS_DATA_W-1:0]  bus_q_wdata_o;
    logic [`BUS_STRB_W-1:0]  bus_q_strb_o;
    bus_size_e               bus_q_size_o;
    logic                    bus_p_valid_i;
    logic                    bus_p_ready_o;
    logic [`BUS_DATA_W-1:0]  bus_p_rdata_i;
    logic                    bus_p_error_i;

    integer seed = 32'h28b5339e;

    // Memory model state
    logic [63:0] mem [MEM_WORDS];
    logic [63:0] rsp_data_q [$];
    logic        rsp_err_q [$];
    int          ready_wait;
    int          rsp_delay;
    logic        rsp_taken;
    logic [31:0] last_addr;
    bus_size_e   last_size;
    bus_size_e   size_log [$];

    core_bus_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------
    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        report_failure();
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_error(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: expected error %b, actual error %b", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_size(input string name, input bus_size_e exp, input bus_size_e act);
        if (exp !== act) begin
            $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
            report_failure();
        end
    endtask

    // ----------------------------------------
    // Bus memory model
    // ----------------------------------------
    function automatic logic [31:0] mem_lane(input logic [31:0] addr);
        return addr[2] ? mem[addr[12:3]][63:32] : mem[addr[12:3]][31:0];
    endfunction

    // Writes land at acceptance, reads are captured then and answered in order
    task automatic take_request();
        logic [63:0] word;
        logic        err;
        logic [9:0]  idx;
        idx  = bus_q_addr_o[12:3];
        err  = (bus_q_addr_o >= ERR_BASE);
        word = mem[idx];
        if (bus_q_write_o && !err) begin
            for (int b = 0; b < 8; b++) begin
                if (bus_q_strb_o[b]) begin
                    word[8*b +: 8] = bus_q_wdata_o[8*b +: 8];
                end
            end
            mem[idx] = word;
        end
        if (rsp_data_q.size() == 0) begin
            rsp_delay = {$random(seed)} % 4;
        end
        rsp_data_q.push_back(word);
        rsp_err_q.push_back(err);
        last_addr  = bus_q_addr_o;
        last_size  = bus_q_size_o;
        size_log.push_back(bus_q_size_o);
        ready_wait = {$random(seed)} % 4;
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (bus_p_valid_i && bus_p_ready_o) begin
                void'(rsp_data_q.pop_front());
                void'(rsp_err_q.pop_front());
                rsp_taken = 1'b1;
                rsp_delay = {$random(seed)} % 4;
            end
            if (bus_q_valid_o && bus_q_ready_i) begin
                take_request();
            end
        end
    end

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            bus_q_ready_i = 1'b0;
            bus_p_valid_i = 1'b0;
        end else begin
            // Ready stays low for a few cycles after each acceptance
            if (ready_wait > 0) begin
                bus_q_ready_i = 1'b0;
                ready_wait--;
            end else begin
                bus_q_ready_i = 1'b1;
            end
            if (rsp_taken) begin
                bus_p_valid_i = 1'b0;
                rsp_taken     = 1'b0;
            end
            if (!bus_p_valid_i && rsp_data_q.size() != 0) begin
                if (rsp_delay == 0) begin
                    bus_p_valid_i = 1'b1;
                    bus_p_rdata_i = rsp_data_q[0];
                    bus_p_error_i = rsp_err_q[0];
                end else begin
                    rsp_delay--;
                end
            end
        end
    end

    // ----------------------------------------
    // Core side transactions
    // ----------------------------------------
    task automatic fetch_word(input string name, input logic [31:0] addr);
        logic [31:0] exp_word;
        int          cycles;
        exp_word = mem_lane(addr);
        @(negedge clk_i);
        inst_req_i  = 1'b1;
        inst_addr_i = addr;
        cycles      = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                timed_out("fetch acknowledge");
            end
        end while (!inst_ack_o);
        check_word(name, exp_word, inst_rdata_o);
        @(negedge clk_i);
        inst_req_i = 1'b0;
    endtask

    task automatic data_access(input string name, input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb);
        logic [31:0] exp_word;
        logic        exp_err;
        int          cycles;
        exp_err  = (addr >= ERR_BASE);
        exp_word = mem_lane(addr);
        // Old word with the strobed bytes replaced
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    exp_word[8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        @(negedge clk_i);
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_strb_i  = strb;
        cycles       = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                timed_out("data acknowledge");
            end
        end while (!data_ack_o);
        check_error(name, exp_err, data_error_o);
        if (!we && !exp_err) begin
            check_word(name, exp_word, data_rdata_o);
        end
        if (we && !exp_err) begin
            check_word(name, exp_word, mem_lane(addr));
        end
        @(negedge clk_i);
        data_req_i = 1'b0;
    endtask

    task automatic random_fetches(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            fetch_word("random fetch", r & 32'h0000_0ffc);
        end
    endtask

    // Data region is kept apart from the fetch region
    task automatic random_data(input int count);
        logic [31:0] r;
        logic [31:0] addr;
        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            addr = 32'h0000_1000 | (r & 32'h0000_0ffc);
            if (r[31:29] == 3'b000) begin
                addr = ERR_BASE | (r & 32'h0000_0ffc);
            end
            data_access("random data", r[28], addr, $random(seed), r[15:12]);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_fetch_lanes();
        logic [31:0] base;
        base = 32'h0000_0200 | ({$random(seed)} & 32'h0000_01f8);
        fetch_word("fetch_lanes low", base);
        check_word("fetch_lanes low addr", base, last_addr);
        check_size("fetch_lanes low size", SIZE_DWORD, last_size);
        fetch_word("fetch_lanes high", base + 32'd4);
        check_word("fetch_lanes high addr", base, last_addr);
        check_size("fetch_lanes high size", SIZE_DWORD, last_size);
    endtask

    task automatic test_store_merge();
        data_access("store_merge low store", 1'b1, 32'h0000_1200, 32'ha5c3_5a3c, 4'b0101);
        check_size("store_merge low size", SIZE_WORD, last_size);
        check_word("store_merge low addr", 32'h0000_1200, last_addr);
        data_access("store_merge low load", 1'b0, 32'h0000_1200, 32'h0, 4'b0000);
        data_access("store_merge high store", 1'b1, 32'h0000_1204, 32'h1e2d_3c4b, 4'b1010);
        check_size("store_merge high size", SIZE_WORD, last_size);
        check_word("store_merge high addr", 32'h0000_1204, last_addr);
        data_access("store_merge high load", 1'b0, 32'h0000_1204, 32'h0, 4'b0000);
    endtask

    task automatic test_bus_error();
        data_access("bus_error above", 1'b0, 32'h0000_f010, 32'h0, 4'b0000);
        data_access("bus_error below", 1'b0, 32'h0000_1310, 32'h0, 4'b0000);
    endtask

    task automatic test_round_robin();
        bus_size_e exp_size;
        size_log.delete();
        fork
            random_fetches(6);
            random_data(6);
        join
        check_word("round_robin count", 32'd12, 32'(size_log.size()));
        for (int i = 1; i < size_log.size(); i++) begin
            exp_size = (size_log[i-1] == SIZE_WORD) ? SIZE_DWORD : SIZE_WORD;
            check_size("round_robin order", exp_size, size_log[i]);
        end
    endtask

    task automatic test_random_mix();
        fork
            random_fetches(30);
            random_data(30);
        join
    endtask

    initial begin
        logic [9:0] k;
        rst_ni        = 1'b0;
        inst_req_i    = 1'b0;
        inst_addr_i   = '0;
        data_req_i    = 1'b0;
        data_we_i     = 1'b0;
        data_addr_i   = '0;
        data_wdata_i  = '0;
        data_strb_i   = '0;
        bus_q_ready_i = 1'b0;
        bus_p_valid_i = 1'b0;
        bus_p_rdata_i = '0;
        bus_p_error_i = 1'b0;
        ready_wait    = 0;
        rsp_delay     = 0;
        rsp_taken     = 1'b0;
        k             = '0;
        repeat (MEM_WORDS) begin
            mem[k] = {$random(seed), $random(seed)};
            k++;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_fetch_lanes();
        test_store_merge();
        test_bus_error();
        test_round_robin();
        test_random_mix();

        if (i_dut.i_chk.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Assertion failures seen: %0d", i_dut.i_chk.fail_cnt);
            report_failure();
        end
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/bus_pkg.sv
hw/inst_fetch_bridge.sv
hw/data_access_bridge.sv
hw/bus_arbiter.sv
hw/core_bus_top.sv
tests/core_bus_chk.sv
tests/core_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module core_bus_tb \
    -Mdir "$BUILD_DIR" -o core_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after an assertion error so the testbench reports the result
"./$BUILD_DIR/core_bus_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1
